// File: testbench/fetch_input.txt
# vm bypass satp kind target gap count stall_mask present first_pc, all hex
# kind bits 4 flush, 2 branch, 1 jump; present bit n marks frame n
0 0 00000000 0 00000000 0 6 0 0 00001000
0 0 00000000 0 00000000 0 6 3 0 00001018
0 0 00000000 4 00002000 2 4 0 0 00002000
0 0 00000000 2 00001000 2 3 1 0 00001000
0 0 00000000 1 00003040 0 2 0 0 00003040
0 0 00000000 7 00004000 0 3 0 0 00004000
0 0 00000000 3 00005000 0 2 1 0 00005000
1 0 00000010 4 00003000 0 5 0 ffffffff 00003000
1 0 00000010 0 00000000 0 3 7 ffffffff 00003014
1 0 00000010 1 00003000 0 4 0 ffffffff 00003000
1 0 00000010 2 00020000 0 1 0 ffffffff 00020000
1 0 00000010 1 00005000 0 3 0 ffffffff 00005000
1 0 00000010 1 00006000 0 1 3 ffffffff 00006000
1 0 00000010 1 00007000 0 1 0 ffffffff 00007000
1 0 00000010 2 00008000 0 2 0 ffffffff 00008000
1 0 00000010 1 00003000 0 2 1 ffffffff 00003000
1 1 00000010 4 00003000 0 3 0 ffffffff 00003000
1 0 000000f0 4 00012000 0 4 3 4 00012000
1 0 000000f0 1 00013000 0 1 1 4 00013000
0 0 00000000 4 000ffff8 0 4 1 0 000ffff8
0 0 00000000 0 00000000 0 6 3 0 00000008
0 0 00000000 1 00000100 2 3 0 0 00000100
0 0 00000000 0 00000000 0 5 7 0 0000010c

// File: tb.f
+incdir+source
source/fetch_pkg.sv
source/tlb_entry.sv
source/itlb.sv
source/ptw.sv
source/instr_cache.sv
source/fetch_stage.sv
testbench/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f tb.f --top-module fetch_tb -o fetch_sim

output=$(./obj_dir/fetch_sim)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// File: testbench/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_tb;

  import fetch_pkg::*;

  localparam int WAIT_LIMIT = 300;
  localparam int LINE_W     = `LINE_BYTES * 8;
  localparam int FRAMES     = 1 << `PPN_WIDTH;

  localparam int M_IDLE      = 0;
  localparam int M_GNT_DELAY = 1;
  localparam int M_GRANT     = 2;
  localparam int M_LINE      = 3;

  logic clk_i = 1'b0;
  logic rst_i;

  logic                    vm_en;
  logic                    trap_bypass;
  logic                    ppn_is_present;
  logic                    flush;
  logic                    branch_taken;
  logic                    is_jump;
  logic                    dec_stall;
  logic [`ADDR_WIDTH-1:0]  satp;
  logic [`ADDR_WIDTH-1:0]  flush_pc;
  logic [`ADDR_WIDTH-1:0]  branch_pc;
  logic [`ADDR_WIDTH-1:0]  jump_pc;
  logic                    instr_valid = 1'b0;
  logic [LINE_W-1:0]       instr_line = '0;
  logic                    mem_gnt = 1'b0;

  logic                    present_req;
  logic [`PPN_WIDTH-1:0]   present_ppn;
  logic                    rd_req_valid;
  logic [`PADDR_WIDTH-1:0] mem_req_addr;
  access_size_t            access_size;
  logic                    dec_valid;
  logic                    dec_excpt;
  logic [`ADDR_WIDTH-1:0]  dec_pc;
  excpt_cause_t            dec_cause;
  logic [`INSTR_WIDTH-1:0] dec_instr;

  logic [FRAMES-1:0] present_map;

  // Current step as read from the stimulus file
  logic [31:0]       step_vm;
  logic [31:0]       step_bypass;
  logic [31:0]       step_satp;
  logic [31:0]       step_kind;
  logic [31:0]       step_target;
  logic [31:0]       step_gap;
  logic [31:0]       step_count;
  logic [31:0]       step_mask;
  logic [FRAMES-1:0] step_present;
  logic [31:0]       step_first;

  int    error_count;
  int    timeout_count;
  int    step_index;
  int    item_count;
  logic  aborted;
  int    fd;
  int    fields;
  int    got_chars;
  string text_line;

  int                      mem_phase = M_IDLE;
  int                      mem_wait;
  logic [`PADDR_WIDTH-1:0] fill_addr;

  always #2 clk_i = ~clk_i;

  // Present table answers in the same cycle
  assign ppn_is_present = present_map[present_ppn];

  fetch_stage dut (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .vm_en_i             (vm_en),
    .trap_bypass_mmu_i   (trap_bypass),
    .ppn_is_present_i    (ppn_is_present),
    .flush_i             (flush),
    .alu_branch_taken_i  (branch_taken),
    .is_jump_i           (is_jump),
    .dec_stall_i         (dec_stall),
    .satp_data_i         (satp),
    .next_pc_flush_i     (flush_pc),
    .pc_branch_offset_i  (branch_pc),
    .jump_address_i      (jump_pc),
    .instr_valid_i       (instr_valid),
    .instr_line_i        (instr_line),
    .mem_gnt_i           (mem_gnt),
    .present_table_req_o (present_req),
    .present_table_ppn_o (present_ppn),
    .rd_req_valid_o      (rd_req_valid),
    .mem_req_addr_o      (mem_req_addr),
    .req_access_size_o   (access_size),
    .dec_valid_o         (dec_valid),
    .dec_excpt_o         (dec_excpt),
    .dec_pc_o            (dec_pc),
    .dec_excpt_cause_o   (dec_cause),
    .dec_instr_o         (dec_instr)
  );

  function automatic logic [31:0] word_at(input logic [`PADDR_WIDTH-1:0] addr);
    return {{(32 - `PADDR_WIDTH){1'b0}}, addr} ^ 32'h13572468;
  endfunction

  function automatic logic [LINE_W-1:0] line_at(input logic [`PADDR_WIDTH-1:0] base);
    logic [LINE_W-1:0] data;
    data = '0;
    for (int w = 0; w < `LINE_BYTES / 4; w++) begin
      data[w*32 +: 32] = word_at(base + `PADDR_WIDTH'(4 * w));
    end
    return data;
  endfunction

  // Memory port grants after 0..3 edges and returns the line 1..4 edges later
  always @(posedge clk_i) begin
    mem_gnt     <= 1'b0;
    instr_valid <= 1'b0;
    if (!rst_i) begin
      mem_phase = M_IDLE;
    end else begin
      case (mem_phase)
        M_IDLE: begin
          if (rd_req_valid) begin
            fill_addr = mem_req_addr;
            mem_wait  = int'($urandom % 32'd4);
            if (mem_wait == 0) begin
              mem_gnt   <= 1'b1;
              mem_phase = M_GRANT;
            end else begin
              mem_phase = M_GNT_DELAY;
            end
          end
        end
        M_GNT_DELAY: begin
          mem_wait = mem_wait - 1;
          if (mem_wait == 0) begin
            mem_gnt   <= 1'b1;
            mem_phase = M_GRANT;
          end
        end
        M_GRANT: begin
          // Grant taken by the cache at this edge
          mem_wait  = 1 + int'($urandom % 32'd4);
          mem_phase = M_LINE;
        end
        default: begin
          mem_wait = mem_wait - 1;
          if (mem_wait == 0) begin
            instr_valid <= 1'b1;
            instr_line  <= line_at(fill_addr);
            mem_phase = M_IDLE;
          end
        end
      endcase
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  // Nothing goes to decode, memory or the present table
  task automatic check_outputs_idle();
    check_value("dec_valid_o", 32'(dec_valid), 32'd0);
    check_value("rd_req_valid_o", 32'(rd_req_valid), 32'd0);
    check_value("present_table_req_o", 32'(present_req), 32'd0);
  endtask

  // Frame rule and memory rule applied to one PC
  task automatic expect_item(input logic [31:0] pc, output logic fault,
                             output logic [31:0] instr);
    logic [`PPN_WIDTH-1:0]   frame;
    logic [`PADDR_WIDTH-1:0] phys;
    fault = 1'b0;
    phys  = pc[`PADDR_WIDTH-1:0];
    if (vm_en && !trap_bypass) begin
      frame = satp[`PPN_WIDTH-1:0] + pc[`PAGE_OFFSET_WIDTH +: `PPN_WIDTH];
      phys  = {frame, pc[`PAGE_OFFSET_WIDTH-1:0]};
      fault = !present_map[frame];
    end
    instr = word_at(phys);
  endtask

  // Mode changes only travel with a redirect
  task automatic apply_redirect();
    @(posedge clk_i);
    vm_en        <= step_vm[0];
    trap_bypass  <= step_bypass[0];
    satp         <= step_satp;
    present_map  <= step_present;
    dec_stall    <= 1'b1;
    flush        <= step_kind[2];
    branch_taken <= step_kind[1];
    is_jump      <= step_kind[0];
    flush_pc     <= step_target;
    // Losing sources point somewhere else
    branch_pc    <= step_kind[2] ? step_target + 32'h800 : step_target;
    jump_pc      <= (step_kind[2] || step_kind[1]) ? step_target + 32'h400 : step_target;
  endtask

  task automatic wait_delivery();
    int   cycles;
    logic got;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      flush        <= 1'b0;
      branch_taken <= 1'b0;
      is_jump      <= 1'b0;
      dec_stall    <= (($urandom & step_mask) != 32'd0);
      @(negedge clk_i);
      got = dec_valid && !dec_stall;
      cycles++;
    end
    if (!got) begin
      $display("Timeout: nothing delivered to decode within %0d cycles in step %0d",
               WAIT_LIMIT, step_index);
      timeout_count++;
      aborted = 1'b1;
    end
  endtask

  task automatic run_step();
    logic [`ADDR_WIDTH-1:0]  exp_pc;
    logic                    exp_fault;
    logic [`INSTR_WIDTH-1:0] exp_instr;
    int                      n;
    step_index++;
    // Decode held off while the next fill is in flight
    repeat (int'(step_gap)) begin
      @(posedge clk_i);
      dec_stall <= 1'b1;
    end
    if (step_kind != 32'd0) begin
      apply_redirect();
    end
    exp_pc = step_first;
    n      = 0;
    while (n < int'(step_count) && !aborted) begin
      wait_delivery();
      if (!aborted) begin
        expect_item(exp_pc, exp_fault, exp_instr);
        check_value("dec_pc_o", dec_pc, exp_pc);
        check_value("dec_excpt_o", 32'(dec_excpt), 32'(exp_fault));
        check_value("req_access_size_o", 32'(access_size), 32'(WORD));
        if (!(vm_en && !trap_bypass)) begin
          check_value("present_table_req_o", 32'(present_req), 32'd0);
        end
        if (exp_fault) begin
          check_value("dec_excpt_cause_o", 32'(dec_cause), 32'(INSTR_PAGE_FAULT));
        end else begin
          check_value("dec_excpt_cause_o", 32'(dec_cause), 32'(NONE));
          check_value("dec_instr_o", dec_instr, exp_instr);
        end
        exp_pc = (exp_pc + 32'd4) % `MEM_SIZE;
        item_count++;
      end
      n++;
    end
  endtask

  initial begin
    void'($urandom(32'h8b03));
    rst_i         = 1'b0;
    vm_en         = 1'b0;
    trap_bypass   = 1'b0;
    flush         = 1'b0;
    branch_taken  = 1'b0;
    is_jump       = 1'b0;
    dec_stall     = 1'b0;
    satp          = '0;
    flush_pc      = '0;
    branch_pc     = '0;
    jump_pc       = '0;
    present_map   = '0;
    step_mask     = '0;
    error_count   = 0;
    timeout_count = 0;
    step_index    = 0;
    item_count    = 0;
    aborted       = 1'b0;

    repeat (7) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_outputs_idle();
    end
    @(posedge clk_i);
    rst_i <= 1'b1;
    @(negedge clk_i);
    check_outputs_idle();

    fd = $fopen("testbench/fetch_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file testbench/fetch_input.txt");
      error_count++;
    end else begin
      got_chars = $fgets(text_line, fd);
      while (got_chars != 0 && !aborted) begin
        fields = $sscanf(text_line, "%h %h %h %h %h %h %h %h %h %h",
                         step_vm, step_bypass, step_satp, step_kind, step_target,
                         step_gap, step_count, step_mask, step_present, step_first);
        // Comment and blank lines do not scan
        if (fields == 10) begin
          run_step();
        end
        got_chars = $fgets(text_line, fd);
      end
      $fclose(fd);
    end

    $display("Summary: %0d steps, %0d items, %0d errors, %0d timeouts",
             step_index, item_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0 && step_index > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : fetch_tb

// File: source/fetch_stage.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_stage (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         vm_en_i,
  input  logic                         trap_bypass_mmu_i,
  input  logic                         ppn_is_present_i,
  input  logic                         flush_i,
  input  logic                         alu_branch_taken_i,
  input  logic                         is_jump_i,
  input  logic                         dec_stall_i,
  input  logic [`ADDR_WIDTH-1:0]       satp_data_i,
  input  logic [`ADDR_WIDTH-1:0]       next_pc_flush_i,
  input  logic [`ADDR_WIDTH-1:0]       pc_branch_offset_i,
  input  logic [`ADDR_WIDTH-1:0]       jump_address_i,
  input  logic                         instr_valid_i,
  input  logic [`LINE_BYTES*8-1:0]     instr_line_i,
  input  logic                         mem_gnt_i,
  output logic                         present_table_req_o,
  output logic [`PPN_WIDTH-1:0]        present_table_ppn_o,
  output logic                         rd_req_valid_o,
  output logic [`PADDR_WIDTH-1:0]      mem_req_addr_o,
  output fetch_pkg::access_size_t      req_access_size_o,
  output logic                         dec_valid_o,
  output logic                         dec_excpt_o,
  output logic [`ADDR_WIDTH-1:0]       dec_pc_o,
  output fetch_pkg::excpt_cause_t      dec_excpt_cause_o,
  output logic [`INSTR_WIDTH-1:0]      dec_instr_o
);

  import fetch_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE       = 3'd0,
    S_REQ        = 3'd1,
    S_WAIT       = 3'd2,
    S_STALL      = 3'd3,
    S_FLUSH_WAIT = 3'd4
  } state_t;

  state_t state, state_d;

  logic [`ADDR_WIDTH-1:0]  pc, pc_d, pc_next;
  vaddr_t                  pc_va;
  logic                    halted, halted_d;
  logic                    mmu_en;
  logic                    redirect;
  logic [`ADDR_WIDTH-1:0]  redirect_pc;
  logic                    fill_busy;
  logic [`PADDR_WIDTH-1:0] paddr;
  logic                    item_ready;
  logic                    item_fault;

  // Stall buffer
  logic                    buf_wr;
  logic                    buf_excpt;
  logic [`INSTR_WIDTH-1:0] buf_instr;

  logic                    itlb_hit;
  logic                    itlb_wr_en;
  logic [`PPN_WIDTH-1:0]   itlb_ppn;

  logic                    iptw_req;
  logic                    iptw_valid;
  logic                    iptw_error;
  logic [`PPN_WIDTH-1:0]   iptw_ppn;
  logic [`PADDR_WIDTH-1:0] iptw_paddr;

  logic                    cache_req;
  logic                    cache_hit;
  logic                    cache_rvalid;
  logic [`INSTR_WIDTH-1:0] cache_rdata;

  assign pc_va     = pc;
  assign pc_next   = `ADDR_WIDTH'((pc + `ADDR_WIDTH'(4)) % `MEM_SIZE);
  assign mmu_en    = vm_en_i && !trap_bypass_mmu_i;
  assign redirect  = flush_i || alu_branch_taken_i || is_jump_i;
  assign fill_busy = (state == S_WAIT) || (state == S_FLUSH_WAIT);

  // Flush beats branch beats jump
  always_comb begin
    if (flush_i) begin
      redirect_pc = next_pc_flush_i;
    end else if (alu_branch_taken_i) begin
      redirect_pc = pc_branch_offset_i;
    end else begin
      redirect_pc = jump_address_i;
    end
  end

  itlb u_itlb (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .flush_i (flush_i),
    .wr_en_i (itlb_wr_en),
    .vaddr_i (pc_va),
    .ppn_i   (iptw_ppn),
    .hit_o   (itlb_hit),
    .ppn_o   (itlb_ppn)
  );

  ptw u_ptw (
    .req_i            (iptw_req),
    .ppn_is_present_i (ppn_is_present_i),
    .vaddr_i          (pc_va),
    .satp_i           (satp_data_i),
    .valid_o          (iptw_valid),
    .error_o          (iptw_error),
    .ppn_o            (iptw_ppn),
    .paddr_o          (iptw_paddr)
  );

  instr_cache u_cache (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .inv_i        (flush_i),
    .req_i        (cache_req),
    .addr_i       (paddr),
    .size_i       (req_access_size_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_rvalid_i (instr_valid_i),
    .mem_line_i   (instr_line_i),
    .hit_o        (cache_hit),
    .rvalid_o     (cache_rvalid),
    .rdata_o      (cache_rdata),
    .mem_req_o    (rd_req_valid_o),
    .mem_addr_o   (mem_req_addr_o)
  );

  assign present_table_ppn_o = iptw_ppn;
  assign req_access_size_o   = WORD;
  assign dec_pc_o            = pc;

  always_comb begin
    state_d             = state;
    pc_d                = pc;
    halted_d            = halted;
    itlb_wr_en          = 1'b0;
    iptw_req            = 1'b0;
    present_table_req_o = 1'b0;
    cache_req           = 1'b0;
    paddr               = pc_va.word[`PADDR_WIDTH-1:0];
    item_ready          = 1'b0;
    item_fault          = 1'b0;
    buf_wr              = 1'b0;
    dec_valid_o         = 1'b0;
    dec_excpt_o         = 1'b0;
    dec_excpt_cause_o   = NONE;
    dec_instr_o         = '0;

    if (redirect) begin
      pc_d     = redirect_pc;
      halted_d = 1'b0;
      // An outstanding fill must drain before the new fetch
      state_d  = (fill_busy && !cache_rvalid) ? S_FLUSH_WAIT : S_REQ;
    end else begin
      case (state)
        S_IDLE: begin
          if (!halted) begin
            state_d = S_REQ;
          end
        end
        S_REQ: begin
          if (mmu_en) begin
            if (itlb_hit) begin
              paddr = {itlb_ppn, pc_va.fields.offset};
            end else begin
              iptw_req            = 1'b1;
              present_table_req_o = 1'b1;
              paddr               = iptw_paddr;
              itlb_wr_en          = iptw_valid;
              item_fault          = iptw_error;
            end
          end
          if (item_fault) begin
            item_ready = 1'b1;
          end else begin
            cache_req = 1'b1;
            if (cache_hit) begin
              item_ready = 1'b1;
            end else begin
              state_d = S_WAIT;
            end
          end
        end
        S_WAIT: begin
          cache_req = 1'b1;
          if (cache_rvalid) begin
            item_ready = 1'b1;
          end
        end
        S_FLUSH_WAIT: begin
          // Abandoned line is dropped here
          if (cache_rvalid) begin
            state_d = S_REQ;
          end
        end
        S_STALL: begin
          dec_valid_o       = 1'b1;
          dec_excpt_o       = buf_excpt;
          dec_excpt_cause_o = buf_excpt ? INSTR_PAGE_FAULT : NONE;
          dec_instr_o       = buf_instr;
          if (!dec_stall_i) begin
            if (buf_excpt) begin
              halted_d = 1'b1;
              state_d  = S_IDLE;
            end else begin
              pc_d    = pc_next;
              state_d = S_REQ;
            end
          end
        end
        default: state_d = S_IDLE;
      endcase

      // Hand the item to decode or park it
      if (item_ready) begin
        if (dec_stall_i) begin
          buf_wr  = 1'b1;
          state_d = S_STALL;
        end else begin
          dec_valid_o       = 1'b1;
          dec_excpt_o       = item_fault;
          dec_excpt_cause_o = item_fault ? INSTR_PAGE_FAULT : NONE;
          dec_instr_o       = item_fault ? '0 : cache_rdata;
          if (item_fault) begin
            halted_d = 1'b1;
            state_d  = S_IDLE;
          end else begin
            pc_d    = pc_next;
            state_d = S_REQ;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state  <= S_IDLE;
      pc     <= `ADDR_WIDTH'(`RESET_PC);
      halted <= 1'b0;
    end else begin
      state  <= state_d;
      pc     <= pc_d;
      halted <= halted_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_wr) begin
      buf_excpt <= item_fault;
      buf_instr <= item_fault ? '0 : cache_rdata;
    end
  end

endmodule : fetch_stage

// File: source/instr_cache.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module instr_cache (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      inv_i,
  input  logic                      req_i,
  input  logic [`PADDR_WIDTH-1:0]   addr_i,
  input  fetch_pkg::access_size_t   size_i,
  input  logic                      mem_gnt_i,
  input  logic                      mem_rvalid_i,
  input  logic [`LINE_BYTES*8-1:0]  mem_line_i,
  output logic                      hit_o,
  output logic                      rvalid_o,
  output logic [`INSTR_WIDTH-1:0]   rdata_o,
  output logic                      mem_req_o,
  output logic [`PADDR_WIDTH-1:0]   mem_addr_o
);

  import fetch_pkg::*;

  localparam int OFF_W  = $clog2(`LINE_BYTES);
  localparam int IDX_W  = $clog2(`CACHE_LINES);
  localparam int TAG_W  = `PADDR_WIDTH - OFF_W - IDX_W;
  localparam int WORDS  = `LINE_BYTES / 4;
  localparam int WSEL_W = (WORDS > 1) ? $clog2(WORDS) : 1;

  typedef enum logic [1:0] {
    C_IDLE      = 2'd0,
    C_REQ       = 2'd1,
    C_WAIT_LINE = 2'd2,
    C_DELIVER   = 2'd3
  } cstate_t;

  cstate_t state, state_d;

  logic [TAG_W-1:0]         tag_mem  [`CACHE_LINES];
  logic [`LINE_BYTES*8-1:0] data_mem [`CACHE_LINES];
  logic [`CACHE_LINES-1:0]  valid_q;

  logic [`PADDR_WIDTH-1:0] miss_addr;
  logic [`PADDR_WIDTH-1:0] rd_addr;
  logic [IDX_W-1:0]        rd_idx;
  logic [TAG_W-1:0]        rd_tag;
  logic [WSEL_W-1:0]       rd_word;
  logic [IDX_W-1:0]        fill_idx;
  logic                    legal_req;
  logic                    line_wr;

  // Fetches are word sized, anything else never looks up
  assign legal_req = req_i && (size_i == WORD);

  // Delivery reads back the line that was just filled
  assign rd_addr = (state == C_DELIVER) ? miss_addr : addr_i;
  assign rd_idx  = rd_addr[OFF_W +: IDX_W];
  assign rd_tag  = rd_addr[`PADDR_WIDTH-1 -: TAG_W];
  assign rd_word = rd_addr[2 +: WSEL_W];

  assign hit_o    = (state == C_IDLE) && legal_req && valid_q[rd_idx]
                    && (tag_mem[rd_idx] == rd_tag);
  assign rvalid_o = hit_o || (state == C_DELIVER);
  assign rdata_o  = data_mem[rd_idx][rd_word * 32 +: 32];

  assign fill_idx   = miss_addr[OFF_W +: IDX_W];
  assign line_wr    = (state == C_WAIT_LINE) && mem_rvalid_i;
  assign mem_req_o  = (state == C_REQ);
  assign mem_addr_o = {miss_addr[`PADDR_WIDTH-1:OFF_W], {OFF_W{1'b0}}};

  always_comb begin
    state_d = state;
    case (state)
      C_IDLE: begin
        if (legal_req && !hit_o) begin
          state_d = C_REQ;
        end
      end
      C_REQ: begin
        // Request held until granted
        if (mem_gnt_i) begin
          state_d = C_WAIT_LINE;
        end
      end
      C_WAIT_LINE: begin
        if (mem_rvalid_i) begin
          state_d = C_DELIVER;
        end
      end
      C_DELIVER: begin
        state_d = C_IDLE;
      end
      default: state_d = C_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state <= C_IDLE;
    end else begin
      state <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      if (inv_i) begin
        valid_q <= '0;
      end
      // A line landing during invalidate is fresh, keep it
      if (line_wr) begin
        valid_q[fill_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state == C_IDLE) && legal_req && !hit_o) begin
      miss_addr <= addr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (line_wr) begin
      tag_mem[fill_idx]  <= miss_addr[`PADDR_WIDTH-1 -: TAG_W];
      data_mem[fill_idx] <= mem_line_i;
    end
  end

endmodule : instr_cache

// File: source/ptw.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module ptw (
  input  logic                    req_i,
  input  logic                    ppn_is_present_i,
  input  fetch_pkg::vaddr_t       vaddr_i,
  input  logic [`ADDR_WIDTH-1:0]  satp_i,
  output logic                    valid_o,
  output logic                    error_o,
  output logic [`PPN_WIDTH-1:0]   ppn_o,
  output logic [`PADDR_WIDTH-1:0] paddr_o
);

  logic [`PPN_WIDTH-1:0] table_base;
  logic [`PPN_WIDTH-1:0] vpn_low;

  assign table_base = satp_i[`PPN_WIDTH-1:0];
  assign vpn_low    = vaddr_i.fields.vpn[`PPN_WIDTH-1:0];

  // Single level, frame is base plus low page bits, wrapping
  assign ppn_o   = table_base + vpn_low;
  assign paddr_o = {ppn_o, vaddr_i.fields.offset};

  // Presence answered by the table in the same cycle
  assign valid_o = req_i && ppn_is_present_i;
  assign error_o = req_i && !ppn_is_present_i;

endmodule : ptw

// File: source/itlb.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module itlb (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  logic                  wr_en_i,
  input  fetch_pkg::vaddr_t     vaddr_i,
  input  logic [`PPN_WIDTH-1:0] ppn_i,
  output logic                  hit_o,
  output logic [`PPN_WIDTH-1:0] ppn_o
);

  localparam int PTR_W = (`TLB_ENTRIES > 1) ? $clog2(`TLB_ENTRIES) : 1;

  logic [PTR_W-1:0]        rr_ptr;
  logic [`TLB_ENTRIES-1:0] entry_wr;
  logic [`TLB_ENTRIES-1:0] entry_hit;
  logic [`PPN_WIDTH-1:0]   entry_ppn [`TLB_ENTRIES];

  // Replacement pointer steps on every refill
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      rr_ptr <= '0;
    end else if (wr_en_i) begin
      rr_ptr <= (rr_ptr == PTR_W'(`TLB_ENTRIES - 1)) ? '0 : rr_ptr + PTR_W'(1);
    end
  end

  for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : g_entry
    assign entry_wr[i] = wr_en_i && (rr_ptr == PTR_W'(i));

    tlb_entry u_entry (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .flush_i      (flush_i),
      .wr_en_i      (entry_wr[i]),
      .vpn_i        (vaddr_i.fields.vpn),
      .ppn_i        (ppn_i),
      .lookup_vpn_i (vaddr_i.fields.vpn),
      .hit_o        (entry_hit[i]),
      .ppn_o        (entry_ppn[i])
    );
  end

  assign hit_o = |entry_hit;

  // At most one entry matches
  always_comb begin
    ppn_o = '0;
    for (int i = 0; i < `TLB_ENTRIES; i++) begin
      if (entry_hit[i]) begin
        ppn_o = entry_ppn[i];
      end
    end
  end

endmodule : itlb

// File: source/tlb_entry.sv
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module tlb_entry (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  flush_i,
  input  logic                  wr_en_i,
  input  logic [`VPN_WIDTH-1:0] vpn_i,
  input  logic [`PPN_WIDTH-1:0] ppn_i,
  input  logic [`VPN_WIDTH-1:0] lookup_vpn_i,
  output logic                  hit_o,
  output logic [`PPN_WIDTH-1:0] ppn_o
);

  logic                  valid_q;
  logic [`VPN_WIDTH-1:0] vpn_q;
  logic [`PPN_WIDTH-1:0] ppn_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i || flush_i) begin
      valid_q <= 1'b0;
    end else if (wr_en_i) begin
      valid_q <= 1'b1;
    end
  end

  // Translation payload
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      vpn_q <= vpn_i;
      ppn_q <= ppn_i;
    end
  end

  assign hit_o = valid_q && (vpn_q == lookup_vpn_i);
  assign ppn_o = ppn_q;

endmodule : tlb_entry

// File: source/fetch_pkg.sv
`include "fetch_cfg.svh"

package fetch_pkg;

  typedef struct packed {
    logic [`VPN_WIDTH-1:0]         vpn;
    logic [`PAGE_OFFSET_WIDTH-1:0] offset;
  } vaddr_fields_t;

  // Same word, seen flat or split into page number and offset
  typedef union packed {
    logic [`ADDR_WIDTH-1:0] word;
    vaddr_fields_t          fields;
  } vaddr_t;

  typedef enum logic [3:0] {
    NONE             = 4'd0,
    INSTR_PAGE_FAULT = 4'd12
  } excpt_cause_t;

  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } access_size_t;

endpackage : fetch_pkg

// File: source/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Address and data widths
`define ADDR_WIDTH 32
`define PADDR_WIDTH 20
`define INSTR_WIDTH 32

// Paging, 4 KiB pages
`define PPN_WIDTH 8
`define VPN_WIDTH 20
`define PAGE_OFFSET_WIDTH 12

// Instruction cache geometry
`define LINE_BYTES 16
`define CACHE_LINES 16

`define TLB_ENTRIES 4

// PC wraps inside 1 MiB
`define MEM_SIZE (1 << 20)
`define RESET_PC 4096

`endif
